// File: logic/debug_params.svh
`ifndef DEBUG_PARAMS_SVH
`define DEBUG_PARAMS_SVH

`define WORD_BITS        32

// Command characters
`define CMD_CONTINUOUS   8'h63   // ASCII c
`define CMD_STEP         8'h73   // ASCII s
`define CMD_NEXT         8'h6e   // ASCII n

//////////////////////////////
// Snapshot dump layout
//////////////////////////////

`define PIPE_DUMP_BYTES  55      // Fetch PC plus all four pipeline latches
`define REG_COUNT        32
`define MEM_DUMP_WORDS   16

// Pipeline bytes, then registers, then memory words
`define DUMP_LENGTH      (`PIPE_DUMP_BYTES + (`REG_COUNT + `MEM_DUMP_WORDS) * (`WORD_BITS / 8))

// Bytes the transmitter accepts before it has to return credit
`define TX_CREDITS       4

`endif

// File: logic/debug_pkg.sv
`include "debug_params.svh"

package debug_pkg;

   typedef logic [`WORD_BITS-1:0] word_t;
   typedef logic [7:0]            byte_t;
   typedef logic [7:0]            address_t;   // Debug port into data memory
   typedef logic [7:0]            pc_t;
   typedef logic [4:0]            regAddr_t;

   // Wide enough to count every byte of one dump
   typedef logic [$clog2(`DUMP_LENGTH)-1:0] dumpIndex_t;

   //////////////////////////////
   // Pipeline latches
   //////////////////////////////

   typedef struct packed {
      word_t    instr;
      pc_t      pcNext;
   } ifIdLatch_t;

   typedef struct packed {
      logic [3:0] aluControl;
      word_t      signImm;
      word_t      readData1;
      word_t      readData2;
      logic       aluSrc;
      logic       aluShiftImm;
      logic [3:0] memWrite;      // Byte-lane write enables
      logic       memToReg;
      logic [1:0] memReadWidth;
      regAddr_t   rs;
      regAddr_t   rt;
      regAddr_t   rd;
      regAddr_t   sa;            // Shift amount
      logic       regDst;
      logic       loadImm;
      logic       regWrite;
   } idExLatch_t;

   typedef struct packed {
      regAddr_t   writeReg;
      word_t      writeData;
      word_t      aluOut;
      logic       regWrite;
      logic       memToReg;
      logic [3:0] memWrite;
      logic [1:0] memReadWidth;
   } exMemLatch_t;

   typedef struct packed {
      regAddr_t   writeReg;
      word_t      aluOut;
      word_t      readData;
      logic       regWrite;
      logic       memToReg;
   } memWbLatch_t;

   typedef struct packed {
      pc_t         fetchPc;
      ifIdLatch_t  ifId;
      idExLatch_t  idEx;
      exMemLatch_t exMem;
      memWbLatch_t memWb;
   } pipeSnapshot_t;

   typedef word_t [`REG_COUNT-1:0] regFile_t;

   typedef enum logic [2:0] {
      stateIdle,
      stateContinuous,
      stateStep,
      stateWait,         // One settling cycle after a single step
      stateSend
   } debugState_t;

endpackage

// File: logic/debugControl.sv
`timescale 1ns/1ps
`include "debug_params.svh"

module debugControl
   import debug_pkg::*;
(
   input  logic  clock,
   input  logic  reset,
   input  logic  rxValid,
   input  byte_t rxByte,
   output logic  rxPop,
   input  logic  endOfProgram,
   output logic  pipeEnable,
   output logic  pipeFlush,
   output logic  dumpStart,
   input  logic  dumpDone
);

   debugState_t state;
   debugState_t nextState;
   logic        continuousUsed;   // Continuous run allowed once per reset
   logic        isContinuous;
   logic        isStep;
   logic        isNext;

   assign isContinuous = (rxByte == `CMD_CONTINUOUS);
   assign isStep       = (rxByte == `CMD_STEP);
   assign isNext       = (rxByte == `CMD_NEXT);

   //////////////////////////////
   // Next state and outputs
   //////////////////////////////

   always_comb begin
      nextState  = state;
      rxPop      = 1'b0;
      pipeEnable = 1'b0;

      case (state)
         stateIdle: begin
            rxPop = rxValid;   // Anything offered is consumed
            if (rxValid) begin
               if (isContinuous && !continuousUsed) begin
                  nextState = stateContinuous;
               end else if (isStep) begin
                  nextState = stateStep;
               end
            end
         end

         stateContinuous: begin
            pipeEnable = !endOfProgram;
            if (endOfProgram) begin
               nextState = stateSend;
            end
         end

         stateStep: begin
            rxPop = rxValid;
            if (rxValid && isNext) begin
               pipeEnable = 1'b1;   // Exactly one clock of progress
               nextState  = stateWait;
            end
         end

         stateWait: begin
            nextState = stateSend;
         end

         stateSend: begin
            // Finished programs go back to idle, otherwise keep stepping
            if (dumpDone) begin
               nextState = endOfProgram ? stateIdle : stateStep;
            end
         end

         default: begin
            nextState = stateIdle;
         end
      endcase
   end

   assign pipeFlush = (state == stateIdle);   // Hold the datapath cleared while idle

   //////////////////////////////
   // State register
   //////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         state          <= stateIdle;
         continuousUsed <= 1'b0;
         dumpStart      <= 1'b0;
      end else begin
         state     <= nextState;
         dumpStart <= (nextState == stateSend) && (state != stateSend);
         if (state == stateContinuous) begin
            continuousUsed <= 1'b1;
         end
      end
   end

endmodule

// File: logic/dumpSequencer.sv
`timescale 1ns/1ps
`include "debug_params.svh"

module dumpSequencer
   import debug_pkg::*;
(
   input  logic       clock,
   input  logic       reset,
   input  logic       dumpStart,
   output logic       dumpDone,
   input  logic       creditReturn,
   output logic       txValid,
   output dumpIndex_t byteIndex,
   output logic       memSelect
);

   localparam int CREDIT_BITS = $clog2(`TX_CREDITS + 1);
   localparam logic [CREDIT_BITS-1:0] CREDIT_MAX = CREDIT_BITS'(`TX_CREDITS);

   logic                   active;
   logic [CREDIT_BITS-1:0] credits;
   logic                   sendNow;
   logic                   lastByte;

   assign sendNow  = active && (credits != '0);   // Stall on zero credit
   assign lastByte = (byteIndex == dumpIndex_t'(`DUMP_LENGTH - 1));

   assign txValid   = sendNow;
   assign memSelect = active;   // Memory answers the debug address during a dump

   //////////////////////////////
   // Byte index
   //////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         active    <= 1'b0;
         byteIndex <= '0;
         dumpDone  <= 1'b0;
      end else begin
         dumpDone <= sendNow && lastByte;   // One cycle after the final byte
         if (dumpStart) begin
            active    <= 1'b1;
            byteIndex <= '0;
         end else if (sendNow) begin
            if (lastByte) begin
               active    <= 1'b0;
               byteIndex <= '0;
            end else begin
               byteIndex <= byteIndex + 1'b1;
            end
         end
      end
   end

   //////////////////////////////
   // Transmit credit
   //////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         credits <= CREDIT_MAX;
      end else begin
         case ({sendNow, creditReturn})
            2'b10: credits <= credits - 1'b1;
            2'b01: begin
               if (credits != CREDIT_MAX) begin   // Ignore a stray extra return
                  credits <= credits + 1'b1;
               end
            end
            default: ;   // Both or neither leave the count alone
         endcase
      end
   end

endmodule

// File: logic/snapshotMux.sv
`timescale 1ns/1ps
`include "debug_params.svh"

module snapshotMux
   import debug_pkg::*;
(
   input  pipeSnapshot_t snapshot,
   input  regFile_t      regFile,
   input  word_t         memData,
   input  dumpIndex_t    byteIndex,
   output byte_t         dumpByte,
   output address_t      memAddr
);

   localparam int WORD_BYTES   = `WORD_BITS / 8;
   localparam int PIPE_BYTES   = `PIPE_DUMP_BYTES;
   localparam int REG_BASE     = PIPE_BYTES;
   localparam int MEM_BASE     = REG_BASE + `REG_COUNT * WORD_BYTES;
   localparam int REG_SEL_BITS = $clog2(`REG_COUNT);
   localparam int MEM_SEL_BITS = $clog2(`MEM_DUMP_WORDS);

   logic [PIPE_BYTES*8-1:0] pipeBytes;
   dumpIndex_t              regOffset;
   dumpIndex_t              memOffset;
   logic [REG_SEL_BITS-1:0] regNum;
   logic [MEM_SEL_BITS-1:0] memWord;

   // Most significant byte of a word goes out first
   function automatic byte_t wordByte(word_t value, logic [1:0] lane);
      return value[(WORD_BYTES - 1 - int'(lane)) * 8 +: 8];
   endfunction

   // Pipeline section, narrow fields padded up to a byte
   assign pipeBytes = {
      snapshot.fetchPc,
      snapshot.ifId.instr, snapshot.ifId.pcNext,
      4'b0, snapshot.idEx.aluControl,
      snapshot.idEx.signImm, snapshot.idEx.readData1, snapshot.idEx.readData2,
      7'b0, snapshot.idEx.aluSrc, 7'b0, snapshot.idEx.aluShiftImm,
      4'b0, snapshot.idEx.memWrite, 7'b0, snapshot.idEx.memToReg,
      6'b0, snapshot.idEx.memReadWidth,
      3'b0, snapshot.idEx.rs, 3'b0, snapshot.idEx.rt,
      3'b0, snapshot.idEx.rd, 3'b0, snapshot.idEx.sa,
      7'b0, snapshot.idEx.regDst, 7'b0, snapshot.idEx.loadImm,
      7'b0, snapshot.idEx.regWrite,
      3'b0, snapshot.exMem.writeReg,
      snapshot.exMem.writeData, snapshot.exMem.aluOut,
      7'b0, snapshot.exMem.regWrite, 7'b0, snapshot.exMem.memToReg,
      4'b0, snapshot.exMem.memWrite, 6'b0, snapshot.exMem.memReadWidth,
      3'b0, snapshot.memWb.writeReg,
      snapshot.memWb.aluOut, snapshot.memWb.readData,
      7'b0, snapshot.memWb.regWrite, 7'b0, snapshot.memWb.memToReg
   };

   assign regOffset = byteIndex - dumpIndex_t'(REG_BASE);
   assign memOffset = byteIndex - dumpIndex_t'(MEM_BASE);
   assign regNum    = regOffset[2 +: REG_SEL_BITS];   // Four bytes per register
   assign memWord   = memOffset[2 +: MEM_SEL_BITS];

   always_comb begin
      memAddr = '0;
      if (byteIndex < dumpIndex_t'(REG_BASE)) begin
         dumpByte = pipeBytes[(PIPE_BYTES - 1 - int'(byteIndex)) * 8 +: 8];
      end else if (byteIndex < dumpIndex_t'(MEM_BASE)) begin
         dumpByte = wordByte(regFile[regNum], regOffset[1:0]);
      end else begin
         memAddr  = address_t'(memWord);   // Memory reads back combinationally
         dumpByte = wordByte(memData, memOffset[1:0]);
      end
   end

endmodule

// File: logic/debugTop.sv
`timescale 1ns/1ps

module debugTop
   import debug_pkg::*;
(
   input  logic          clock,
   input  logic          reset,
   input  logic          rxValid,
   input  byte_t         rxByte,
   output logic          rxPop,
   input  logic          endOfProgram,
   input  pipeSnapshot_t snapshot,
   input  regFile_t      regFile,
   input  word_t         memData,
   output logic          pipeEnable,
   output logic          pipeFlush,
   output logic          memSelect,
   output address_t      memAddr,
   output logic          txValid,
   output byte_t         txByte,
   input  logic          creditReturn
);

   logic       dumpStart;
   logic       dumpDone;
   dumpIndex_t byteIndex;

   // Command decode and pipeline control
   debugControl control (
      .clock        (clock),
      .reset        (reset),
      .rxValid      (rxValid),
      .rxByte       (rxByte),
      .rxPop        (rxPop),
      .endOfProgram (endOfProgram),
      .pipeEnable   (pipeEnable),
      .pipeFlush    (pipeFlush),
      .dumpStart    (dumpStart),
      .dumpDone     (dumpDone)
   );

   dumpSequencer sequencer (
      .clock        (clock),
      .reset        (reset),
      .dumpStart    (dumpStart),
      .dumpDone     (dumpDone),
      .creditReturn (creditReturn),
      .txValid      (txValid),
      .byteIndex    (byteIndex),
      .memSelect    (memSelect)
   );

   // Byte select for the transmitter
   snapshotMux mux (
      .snapshot  (snapshot),
      .regFile   (regFile),
      .memData   (memData),
      .byteIndex (byteIndex),
      .dumpByte  (txByte),
      .memAddr   (memAddr)
   );

endmodule

// File: sim/debugTbModel.svh
`ifndef DEBUG_TB_MODEL_SVH
`define DEBUG_TB_MODEL_SVH

//////////////////////////////
// Stimulus source and model
//////////////////////////////

function automatic logic [31:0] nextRandom();
   seed = seed * 32'd1664525 + 32'd1013904223;
   return seed;
endfunction

function automatic void pushByte(byte_t value);
   expectBytes.push_back(value);
endfunction

// Words go out high byte first
function automatic void pushWord(word_t value);
   for (int lane = 3; lane >= 0; lane--) begin
      expectBytes.push_back(value[lane*8 +: 8]);
   end
endfunction

// New datapath contents and the byte stream one dump of them should give
task automatic fillModel();
   logic [$bits(pipeSnapshot_t)-1:0] raw;
   raw = '0;
   for (int i = 0; i < ($bits(pipeSnapshot_t) + 31) / 32; i++) begin
      raw = (raw << 32) | nextRandom();
   end
   snapshot = raw;
   for (int r = 0; r < `REG_COUNT; r++) begin
      regFile[r] = nextRandom();
   end
   for (int a = 0; a < 256; a++) begin
      memory[a] = nextRandom();
   end

   expectBytes = {};
   pushByte(snapshot.fetchPc);
   pushWord(snapshot.ifId.instr);
   pushByte(snapshot.ifId.pcNext);
   pushByte(8'(snapshot.idEx.aluControl));
   pushWord(snapshot.idEx.signImm);
   pushWord(snapshot.idEx.readData1);
   pushWord(snapshot.idEx.readData2);
   pushByte(8'(snapshot.idEx.aluSrc));
   pushByte(8'(snapshot.idEx.aluShiftImm));
   pushByte(8'(snapshot.idEx.memWrite));
   pushByte(8'(snapshot.idEx.memToReg));
   pushByte(8'(snapshot.idEx.memReadWidth));
   pushByte(8'(snapshot.idEx.rs));
   pushByte(8'(snapshot.idEx.rt));
   pushByte(8'(snapshot.idEx.rd));
   pushByte(8'(snapshot.idEx.sa));
   pushByte(8'(snapshot.idEx.regDst));
   pushByte(8'(snapshot.idEx.loadImm));
   pushByte(8'(snapshot.idEx.regWrite));
   pushByte(8'(snapshot.exMem.writeReg));
   pushWord(snapshot.exMem.writeData);
   pushWord(snapshot.exMem.aluOut);
   pushByte(8'(snapshot.exMem.regWrite));
   pushByte(8'(snapshot.exMem.memToReg));
   pushByte(8'(snapshot.exMem.memWrite));
   pushByte(8'(snapshot.exMem.memReadWidth));
   pushByte(8'(snapshot.memWb.writeReg));
   pushWord(snapshot.memWb.aluOut);
   pushWord(snapshot.memWb.readData);
   pushByte(8'(snapshot.memWb.regWrite));
   pushByte(8'(snapshot.memWb.memToReg));
   for (int r = 0; r < `REG_COUNT; r++) begin
      pushWord(regFile[r]);
   end
   for (int w = 0; w < `MEM_DUMP_WORDS; w++) begin
      pushWord(memory[w]);
   end
   assert (expectBytes.size() == `DUMP_LENGTH)
      else reportProblem("Model dump length does not match the layout");
endtask

//////////////////////////////
// UART side
//////////////////////////////

// Called a drive delay after a rising edge, returns the same way
task automatic sendByte(input byte_t value, output logic sawEnable);
   int   waited;
   logic popped;
   waited    = 0;
   popped    = 1'b0;
   sawEnable = 1'b0;
   rxValid   = 1'b1;
   rxByte    = value;
   while (!popped && waited < WAIT_LIMIT) begin
      @(posedge clock);
      popped    = rxPop;
      sawEnable = pipeEnable;   // Enable in the popping cycle
      waited++;
   end
   #DRIVE_DELAY;
   rxValid = 1'b0;
   if (!popped) begin
      reportProblem($sformatf("Command byte %h was never taken by the unit", value));
   end
endtask

task automatic waitDump(input int target);
   int waited;
   waited = 0;
   while (dumpCount < target && waited < WAIT_LIMIT) begin
      @(posedge clock);
      #DRIVE_DELAY;
      waited++;
   end
   if (dumpCount < target) begin
      reportProblem($sformatf("Dump %0d never completed", target));
   end
endtask

task automatic waitIdle();
   int waited;
   waited = 0;
   while (!pipeFlush && waited < 10) begin
      @(posedge clock);
      #DRIVE_DELAY;
      waited++;
   end
   if (!pipeFlush) begin
      reportProblem("Unit did not return to idle after the dump");
   end
endtask

`endif

// File: sim/debugTb.sv
`timescale 1ns/1ps
`include "debug_params.svh"

module debugTb
   import debug_pkg::*;
();

   localparam int CLOCK_PERIOD    = 40;
   localparam int DRIVE_DELAY     = 2;
   localparam int MEM_BASE        = `PIPE_DUMP_BYTES + `REG_COUNT * 4;
   localparam int WAIT_LIMIT      = `DUMP_LENGTH * 8 + 20;
   localparam int WATCHDOG_CYCLES = 4 * `DUMP_LENGTH * 8 + 2000;   // Four dumps plus margin

   logic          clock;
   logic          reset;
   logic          rxValid;
   byte_t         rxByte;
   logic          rxPop;
   logic          endOfProgram;
   pipeSnapshot_t snapshot;
   regFile_t      regFile;
   word_t         memData;
   logic          pipeEnable;
   logic          pipeFlush;
   logic          memSelect;
   address_t      memAddr;
   logic          txValid;
   byte_t         txByte;
   logic          creditReturn;

   word_t         memory [256];
   byte_t         expectBytes [$];
   logic [31:0]   seed;
   int            errors;
   int            testsRun;
   int            testsFailed;
   int            startErrors;
   int            startEnable;
   logic          enabled;
   int            txCount;     // Bytes sent in the current dump
   int            dumpCount;
   int            sentTotal;
   int            returnedTotal;
   int            enableCycles;

   assign memData = memory[memAddr];   // Combinational memory read

   debugTop dut (.*);

   task automatic reportMismatch(input string msg);
      errors++;
      $display("FAILED at %0d ns: %s", $time, msg);
   endtask

   task automatic reportProblem(input string msg);
      errors++;
      $display("Error at %0d ns: %s", $time, msg);
   endtask

   `include "debugTbModel.svh"

   initial begin
      clock = 1'b0;
      forever #(CLOCK_PERIOD / 2) clock = ~clock;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLOCK_PERIOD);
      $display("Timeout: the run did not finish in the expected time");
      $display("TESTBENCH FAILED");
      $finish;
   end

   always @(posedge clock) begin
      if (reset) begin
         txCount       <= 0;
         dumpCount     <= 0;
         sentTotal     <= 0;
         returnedTotal <= 0;
         enableCycles  <= 0;
      end else begin
         if (txValid) begin
            sentTotal <= sentTotal + 1;
            if (txCount == `DUMP_LENGTH - 1) begin
               txCount   <= 0;
               dumpCount <= dumpCount + 1;
            end else begin
               txCount <= txCount + 1;
            end
         end
         if (creditReturn) returnedTotal <= returnedTotal + 1;
         if (pipeEnable) enableCycles <= enableCycles + 1;
      end
   end

   // Transmitter returns credit 1 to 6 cycles after each byte, in order
   initial begin
      int cycle;
      int pending [$];
      cycle        = 0;
      creditReturn = 1'b0;
      forever begin
         @(posedge clock);
         cycle++;
         if (txValid && !reset) pending.push_back(cycle + 1 + int'(nextRandom() % 6));
         #DRIVE_DELAY;
         creditReturn = 1'b0;
         if (pending.size() > 0 && pending[0] <= cycle) begin
            creditReturn = 1'b1;
            void'(pending.pop_front());
         end
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   assert property (@(posedge clock) $fell(reset) |->
         pipeFlush && !pipeEnable && !txValid && !rxPop && !memSelect)
      else reportMismatch("outputs not at idle values after reset");

   assert property (@(posedge clock) disable iff (reset) pipeFlush |-> !pipeEnable && !txValid)
      else reportMismatch("pipeline enabled or byte sent while idle");

   assert property (@(posedge clock) disable iff (reset) (pipeFlush && rxValid) |-> rxPop)
      else reportMismatch("byte offered in idle was not popped");

   assert property (@(posedge clock) disable iff (reset) txValid |-> txByte == expectBytes[txCount])
      else reportMismatch($sformatf("dump byte %0d is %h, expected %h",
                                    txCount, txByte, expectBytes[txCount]));

   assert property (@(posedge clock) disable iff (reset) sentTotal - returnedTotal <= `TX_CREDITS)
      else reportMismatch("more bytes unacknowledged than the credit allows");

   assert property (@(posedge clock) disable iff (reset)
         (txValid && txCount >= MEM_BASE) |->
         memSelect && memAddr == address_t'((txCount - MEM_BASE) / 4) &&
         txByte == memory[memAddr][(3 - (txCount - MEM_BASE) % 4) * 8 +: 8])
      else reportMismatch($sformatf("memory byte %0d wrong at address %0d", txCount, memAddr));

   task automatic finishTest(input int number, input string name);
      testsRun++;
      if (errors != startErrors) testsFailed++;
      $display("Test %0d %s: %s", number, name, (errors == startErrors) ? "ok" : "failed");
      startErrors = errors;
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial begin
      reset        = 1'b1;
      rxValid      = 1'b0;
      rxByte       = '0;
      endOfProgram = 1'b0;
      seed         = 47;
      errors       = 0;
      testsRun     = 0;
      testsFailed  = 0;
      startErrors  = 0;
      fillModel();
      repeat (5) @(posedge clock);
      #DRIVE_DELAY;
      reset = 1'b0;
      @(posedge clock);   // Idle outputs seen with nothing offered
      #DRIVE_DELAY;

      sendByte(8'h71, enabled);   // Unknown byte while idle
      assert (!enabled && pipeFlush) else reportMismatch("idle byte changed the state");
      finishTest(1, "reset and idle pop");

      sendByte(`CMD_STEP, enabled);
      startEnable = enableCycles;
      sendByte(`CMD_NEXT, enabled);
      assert (enabled) else reportMismatch("step gave no pipeline enable");
      waitDump(1);
      assert (enableCycles - startEnable == 1) else reportMismatch("step enable not one cycle");
      sendByte(`CMD_NEXT, enabled);   // Only taken once back in step mode
      assert (enabled) else reportMismatch("second step gave no pipeline enable");
      waitDump(2);
      finishTest(2, "single step and dump");

      fillModel();
      sendByte(`CMD_NEXT, enabled);
      endOfProgram = 1'b1;   // This dump ends the program, so the unit goes idle
      waitDump(3);
      waitIdle();
      endOfProgram = 1'b0;
      finishTest(3, "credit flow under random delays");

      fillModel();
      sendByte(`CMD_CONTINUOUS, enabled);
      startEnable = enableCycles;
      repeat (5) begin
         @(posedge clock);
         assert (pipeEnable) else reportMismatch("pipeline enable dropped in continuous run");
      end
      #DRIVE_DELAY;
      endOfProgram = 1'b1;
      waitDump(4);
      assert (enableCycles - startEnable == 5)
         else reportMismatch("pipeline enabled after end of program");
      waitIdle();
      endOfProgram = 1'b0;
      finishTest(4, "continuous run");

      sendByte(`CMD_CONTINUOUS, enabled);   // Second run is refused
      repeat (6) begin
         @(posedge clock);
         assert (!pipeEnable && pipeFlush) else reportMismatch("second continuous run started");
      end
      #DRIVE_DELAY;
      sendByte(8'h78, enabled);
      repeat (3) begin
         @(posedge clock);
         assert (!pipeEnable && pipeFlush) else reportMismatch("unknown byte had an effect");
      end
      #DRIVE_DELAY;
      finishTest(5, "repeated continuous and unknown bytes");

      $display("Tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// File: list.f
+incdir+logic
+incdir+sim
logic/debug_pkg.sv
logic/debugControl.sv
logic/dumpSequencer.sv
logic/snapshotMux.sv
logic/debugTop.sv
sim/debugTb.sv

// File: Bender.yml
package:
  name: debug_unit

sources:
  - include_dirs:
      - logic
    files:
      - logic/debug_pkg.sv
      - logic/debugControl.sv
      - logic/dumpSequencer.sv
      - logic/snapshotMux.sv
      - logic/debugTop.sv
  - target: simulation
    include_dirs:
      - logic
      - sim
    files:
      - sim/debugTb.sv
